// ==== hdl/cache_cfg_pkg.sv ====
// Cache geometry: address fields, data words and cache line types
package cache_cfg_pkg;

  localparam int ADDR_W    = 12;
  localparam int WORD_W    = 32;
  localparam int TAG_W     = 4;
  localparam int INDEX_W   = 4;
  localparam int TAG_LSB   = 8;
  localparam int INDEX_LSB = 4;
  localparam int WORD_LSB  = 2;
  localparam int LINES     = 2 ** INDEX_W;
  localparam int BLOCK_W   = 128;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [INDEX_W-1:0]     index_t;
  typedef logic [1:0]             word_sel_t;
  typedef logic [1:0]             byte_sel_t;
  typedef logic [BLOCK_W-1:0]     block_t;
  typedef logic [BLOCK_W/8-1:0]   block_mask_t;
  typedef logic [WORD_W/8-1:0]    lane_mask_t;
  typedef logic [ADDR_W-3:0]      mem_index_t;

endpackage

// ==== hdl/cache_ctrl_pkg.sv ====
// Cache control definitions: FSM states, access sizes and byte lanes
package cache_ctrl_pkg;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_t;

  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_CHECK      = 3'd1,
    ST_WRITE_HIT  = 3'd2,
    ST_WRITE_MISS = 3'd3,
    ST_READ_MISS  = 3'd4
  } dcache_state_t;

  // Byte lanes touched by an aligned access
  function automatic cache_cfg_pkg::lane_mask_t lane_mask(
    access_size_t             size,
    cache_cfg_pkg::byte_sel_t offset
  );
    case (size)
      SIZE_BYTE: lane_mask = 4'b0001 << offset;
      SIZE_HALF: lane_mask = offset[1] ? 4'b1100 : 4'b0011;
      default:   lane_mask = 4'b1111;
    endcase
  endfunction

endpackage

// ==== hdl/sram_array.sv ====
// Single-port array with per-lane write enables and registered read
`timescale 1ns/1ps

module sram_array #(
  parameter int WIDTH = 128,
  parameter int LANES = 16
) (
  input  logic                  clk,
  input  cache_cfg_pkg::index_t addr,
  input  logic                  en,
  input  logic [LANES-1:0]      we,
  input  logic [WIDTH-1:0]      wdata,
  output logic [WIDTH-1:0]      rdata
);

  localparam int LANE_W = WIDTH / LANES;

  logic [WIDTH-1:0] mem [cache_cfg_pkg::LINES];

  // Read returns the old contents on a write cycle
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];
      for (int i = 0; i < LANES; i++) begin
        if (we[i]) begin
          mem[addr][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
        end
      end
    end
  end

endmodule

// ==== hdl/dcache_ctrl.sv ====
// Data cache controller: direct mapped, write through, no write allocate
// Runs the access FSM, refills lines and drives the memory port
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        cpu_req,
  input  logic                        cpu_write,
  input  cache_ctrl_pkg::access_size_t cpu_size,
  input  cache_cfg_pkg::addr_t        cpu_addr,
  input  cache_cfg_pkg::word_t        cpu_wdata,
  output logic                        cpu_wait,
  output cache_cfg_pkg::word_t        cpu_rdata,
  output logic                        mem_req,
  output logic                        mem_write,
  output cache_cfg_pkg::addr_t        mem_addr,
  output cache_cfg_pkg::word_t        mem_wdata,
  output cache_ctrl_pkg::access_size_t mem_size,
  input  logic                        mem_ack,
  input  cache_cfg_pkg::word_t        mem_rdata,
  output logic                        tag_en,
  output logic                        tag_we,
  input  cache_cfg_pkg::tag_t         tag_rdata,
  output logic                        data_en,
  output cache_cfg_pkg::block_mask_t  data_we,
  output cache_cfg_pkg::block_t       data_wdata,
  input  cache_cfg_pkg::block_t       data_rdata,
  output cache_cfg_pkg::index_t       index,
  output logic                        rd_hit,
  output logic                        rd_miss,
  output logic                        wr_hit,
  output logic                        wr_miss
);

  cache_ctrl_pkg::dcache_state_t state, state_next;

  cache_cfg_pkg::addr_t         req_addr;
  cache_cfg_pkg::word_t         req_wdata;
  cache_ctrl_pkg::access_size_t req_size;
  logic                         req_write;

  logic [cache_cfg_pkg::LINES-1:0] valid;
  logic [1:0]                      beat;
  cache_cfg_pkg::block_t           refill;
  cache_cfg_pkg::block_t           fill_block;
  cache_cfg_pkg::word_t            wdata_rep;
  cache_cfg_pkg::lane_mask_t       lanes;
  cache_cfg_pkg::word_sel_t        req_word;
  cache_cfg_pkg::byte_sel_t        req_byte;
  logic                            accept;
  logic                            tag_hit;
  logic                            mem_state;

  // Zero-extended load value from a word
  function automatic cache_cfg_pkg::word_t align_read(
    cache_cfg_pkg::word_t         w,
    cache_ctrl_pkg::access_size_t size,
    cache_cfg_pkg::byte_sel_t     off
  );
    case (size)
      cache_ctrl_pkg::SIZE_BYTE: align_read = {24'h0, w[{off, 3'b000} +: 8]};
      cache_ctrl_pkg::SIZE_HALF: align_read = {16'h0, w[{off[1], 4'b0000} +: 16]};
      default:                   align_read = w;
    endcase
  endfunction

  assign req_word = req_addr[cache_cfg_pkg::WORD_LSB +: 2];
  assign req_byte = req_addr[1:0];
  assign accept   = (state == cache_ctrl_pkg::ST_IDLE) && cpu_req;
  assign tag_hit  = (tag_rdata == req_addr[cache_cfg_pkg::TAG_LSB +: cache_cfg_pkg::TAG_W]);
  assign lanes    = cache_ctrl_pkg::lane_mask(req_size, req_byte);

  // Store data comes right aligned, spread it over every lane
  always_comb begin
    case (req_size)
      cache_ctrl_pkg::SIZE_BYTE: wdata_rep = {4{req_wdata[7:0]}};
      cache_ctrl_pkg::SIZE_HALF: wdata_rep = {2{req_wdata[15:0]}};
      default:                   wdata_rep = req_wdata;
    endcase
  end

  // ====================================================================
  // Access FSM
  // ====================================================================
  always_comb begin
    state_next = state;
    case (state)
      cache_ctrl_pkg::ST_IDLE: begin
        if (cpu_req) begin
          if (valid[index])   state_next = cache_ctrl_pkg::ST_CHECK;
          else if (cpu_write) state_next = cache_ctrl_pkg::ST_WRITE_MISS;
          else                state_next = cache_ctrl_pkg::ST_READ_MISS;
        end
      end
      cache_ctrl_pkg::ST_CHECK: begin
        if (req_write) begin
          state_next = tag_hit ? cache_ctrl_pkg::ST_WRITE_HIT : cache_ctrl_pkg::ST_WRITE_MISS;
        end else begin
          state_next = tag_hit ? cache_ctrl_pkg::ST_IDLE : cache_ctrl_pkg::ST_READ_MISS;
        end
      end
      cache_ctrl_pkg::ST_WRITE_HIT,
      cache_ctrl_pkg::ST_WRITE_MISS: if (mem_ack) state_next = cache_ctrl_pkg::ST_IDLE;
      cache_ctrl_pkg::ST_READ_MISS:  if (rd_miss) state_next = cache_ctrl_pkg::ST_IDLE;
      default: state_next = cache_ctrl_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= cache_ctrl_pkg::ST_IDLE;
      beat      <= 2'd0;
      valid     <= '0;
      cpu_rdata <= '0;
    end else begin
      state <= state_next;
      // Wraps back to zero on the fourth ack
      if (state == cache_ctrl_pkg::ST_READ_MISS && mem_ack) beat <= beat + 2'd1;
      if (rd_miss) begin
        valid[index] <= 1'b1;
        cpu_rdata    <= align_read(fill_block[{req_word, 5'b0} +: 32], req_size, req_byte);
      end else if (rd_hit) begin
        cpu_rdata <= align_read(data_rdata[{req_word, 5'b0} +: 32], req_size, req_byte);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= cpu_addr;
      req_wdata <= cpu_wdata;
      req_size  <= cpu_size;
      req_write <= cpu_write;
    end
    if (state == cache_ctrl_pkg::ST_READ_MISS && mem_ack) refill <= fill_block;
  end

  // First word lands in the lowest slot after four shifts
  assign fill_block = {mem_rdata, refill[cache_cfg_pkg::BLOCK_W-1:32]};

  // ====================================================================
  // Events, arrays and memory port
  // ====================================================================
  assign rd_hit  = (state == cache_ctrl_pkg::ST_CHECK) && !req_write && tag_hit;
  assign rd_miss = (state == cache_ctrl_pkg::ST_READ_MISS) && mem_ack && (beat == 2'd3);
  assign wr_hit  = (state == cache_ctrl_pkg::ST_WRITE_HIT) && mem_ack;
  assign wr_miss = (state == cache_ctrl_pkg::ST_WRITE_MISS) && mem_ack;

  assign index = (state == cache_ctrl_pkg::ST_IDLE)
               ? cpu_addr[cache_cfg_pkg::INDEX_LSB +: cache_cfg_pkg::INDEX_W]
               : req_addr[cache_cfg_pkg::INDEX_LSB +: cache_cfg_pkg::INDEX_W];

  assign tag_we     = rd_miss;
  assign tag_en     = accept | tag_we;
  assign data_en    = accept | wr_hit | rd_miss;
  assign data_wdata = rd_miss ? fill_block : {4{wdata_rep}};

  always_comb begin
    if (rd_miss)     data_we = '1;
    else if (wr_hit) data_we = cache_cfg_pkg::block_mask_t'(lanes) << {req_word, 2'b00};
    else             data_we = '0;
  end

  assign mem_state = (state == cache_ctrl_pkg::ST_WRITE_HIT) ||
                     (state == cache_ctrl_pkg::ST_WRITE_MISS);
  assign mem_write = mem_state;
  assign mem_req   = (mem_state || (state == cache_ctrl_pkg::ST_READ_MISS && beat == 2'd0))
                     && !mem_ack;
  assign mem_addr  = (state == cache_ctrl_pkg::ST_READ_MISS) ? {req_addr[11:4], 4'h0} : req_addr;
  assign mem_wdata = wdata_rep;
  assign mem_size  = (state == cache_ctrl_pkg::ST_READ_MISS) ? cache_ctrl_pkg::SIZE_WORD : req_size;
  assign cpu_wait  = (state != cache_ctrl_pkg::ST_IDLE);

endmodule

// ==== hdl/dcache_perf.sv ====
// Saturating hit and miss counters for reads and writes
`timescale 1ns/1ps

module dcache_perf #(
  parameter int COUNT_W = 16
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               rd_hit,
  input  logic               rd_miss,
  input  logic               wr_hit,
  input  logic               wr_miss,
  output logic [COUNT_W-1:0] rd_hits,
  output logic [COUNT_W-1:0] rd_misses,
  output logic [COUNT_W-1:0] wr_hits,
  output logic [COUNT_W-1:0] wr_misses
);

  logic [3:0]         pulse;
  logic [COUNT_W-1:0] count [4];

  assign pulse = {wr_miss, wr_hit, rd_miss, rd_hit};

  for (genvar i = 0; i < 4; i++) begin : g_cnt
    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        count[i] <= '0;
      end else if (pulse[i] && count[i] != '1) begin
        count[i] <= count[i] + 1'b1;
      end
    end
  end

  assign rd_hits   = count[0];
  assign rd_misses = count[1];
  assign wr_hits   = count[2];
  assign wr_misses = count[3];

endmodule

// ==== hdl/dcache.sv ====
// L1 data cache: controller, tag and data arrays, event counters
`timescale 1ns/1ps

module dcache #(
  parameter int COUNT_W = 16
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         cpu_req,
  input  logic                         cpu_write,
  input  cache_ctrl_pkg::access_size_t cpu_size,
  input  cache_cfg_pkg::addr_t         cpu_addr,
  input  cache_cfg_pkg::word_t         cpu_wdata,
  output logic                         cpu_wait,
  output cache_cfg_pkg::word_t         cpu_rdata,
  output logic                         mem_req,
  output logic                         mem_write,
  output cache_cfg_pkg::addr_t         mem_addr,
  output cache_cfg_pkg::word_t         mem_wdata,
  output cache_ctrl_pkg::access_size_t mem_size,
  input  logic                         mem_ack,
  input  cache_cfg_pkg::word_t         mem_rdata,
  output logic [COUNT_W-1:0]           rd_hits,
  output logic [COUNT_W-1:0]           rd_misses,
  output logic [COUNT_W-1:0]           wr_hits,
  output logic [COUNT_W-1:0]           wr_misses
);

  cache_cfg_pkg::index_t      index;
  logic                       tag_en;
  logic                       tag_we;
  cache_cfg_pkg::tag_t        tag_rdata;
  cache_cfg_pkg::tag_t        tag_wdata;
  logic                       data_en;
  cache_cfg_pkg::block_mask_t data_we;
  cache_cfg_pkg::block_t      data_wdata;
  cache_cfg_pkg::block_t      data_rdata;
  logic                       rd_hit;
  logic                       rd_miss;
  logic                       wr_hit;
  logic                       wr_miss;

  // Refill address carries the tag of the line being filled
  assign tag_wdata = mem_addr[cache_cfg_pkg::TAG_LSB +: cache_cfg_pkg::TAG_W];

  dcache_ctrl i_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .cpu_req    (cpu_req),
    .cpu_write  (cpu_write),
    .cpu_size   (cpu_size),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_wait   (cpu_wait),
    .cpu_rdata  (cpu_rdata),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .tag_en     (tag_en),
    .tag_we     (tag_we),
    .tag_rdata  (tag_rdata),
    .data_en    (data_en),
    .data_we    (data_we),
    .data_wdata (data_wdata),
    .data_rdata (data_rdata),
    .index      (index),
    .rd_hit     (rd_hit),
    .rd_miss    (rd_miss),
    .wr_hit     (wr_hit),
    .wr_miss    (wr_miss)
  );

  sram_array #(.WIDTH(cache_cfg_pkg::TAG_W), .LANES(1)) i_tag_array (
    .clk   (clk),
    .addr  (index),
    .en    (tag_en),
    .we    (tag_we),
    .wdata (tag_wdata),
    .rdata (tag_rdata)
  );

  sram_array #(.WIDTH(cache_cfg_pkg::BLOCK_W), .LANES(cache_cfg_pkg::BLOCK_W / 8)) i_data_array (
    .clk   (clk),
    .addr  (index),
    .en    (data_en),
    .we    (data_we),
    .wdata (data_wdata),
    .rdata (data_rdata)
  );

  dcache_perf #(.COUNT_W(COUNT_W)) i_perf (
    .clk       (clk),
    .rstn      (rstn),
    .rd_hit    (rd_hit),
    .rd_miss   (rd_miss),
    .wr_hit    (wr_hit),
    .wr_miss   (wr_miss),
    .rd_hits   (rd_hits),
    .rd_misses (rd_misses),
    .wr_hits   (wr_hits),
    .wr_misses (wr_misses)
  );

endmodule

// ==== hdl/bus_mem.sv ====
// Main memory model: word writes and four-word burst reads after a delay
`timescale 1ns/1ps

module bus_mem #(
  parameter int ACK_DELAY = 3
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         mem_req,
  input  logic                         mem_write,
  input  cache_cfg_pkg::addr_t         mem_addr,
  input  cache_cfg_pkg::word_t         mem_wdata,
  input  cache_ctrl_pkg::access_size_t mem_size,
  output logic                         mem_ack,
  output cache_cfg_pkg::word_t         mem_rdata
);

  localparam int CNT_W = $clog2(ACK_DELAY + 1);

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_WAIT,
    MEM_BURST
  } mem_state_t;

  mem_state_t                state;
  logic [CNT_W-1:0]          cnt;
  logic [1:0]                beat;
  logic                      req_write;
  cache_cfg_pkg::mem_index_t req_index;
  cache_cfg_pkg::word_t      req_wdata;
  cache_cfg_pkg::lane_mask_t req_lanes;
  cache_cfg_pkg::word_t      store [2 ** (cache_cfg_pkg::ADDR_W - 2)];

  initial begin
    foreach (store[i]) store[i] = '0;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= MEM_IDLE;
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
      cnt       <= '0;
      beat      <= 2'd0;
    end else begin
      case (state)
        MEM_IDLE: begin
          mem_ack <= 1'b0;
          if (mem_req) begin
            cnt   <= CNT_W'(ACK_DELAY - 1);
            state <= MEM_WAIT;
          end
        end
        MEM_WAIT: begin
          if (cnt <= CNT_W'(1)) begin
            mem_ack <= 1'b1;
            if (req_write) begin
              for (int i = 0; i < 4; i++) begin
                if (req_lanes[i]) store[req_index][i*8 +: 8] <= req_wdata[i*8 +: 8];
              end
              state <= MEM_IDLE;
            end else begin
              mem_rdata <= store[req_index];
              beat      <= 2'd1;
              state     <= MEM_BURST;
            end
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          // Words follow in address order, one per cycle
          mem_rdata <= store[{req_index[9:2], beat}];
          beat      <= beat + 2'd1;
          if (beat == 2'd3) state <= MEM_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == MEM_IDLE && mem_req) begin
      req_write <= mem_write;
      req_index <= mem_addr[cache_cfg_pkg::ADDR_W-1:2];
      req_wdata <= mem_wdata;
      req_lanes <= cache_ctrl_pkg::lane_mask(mem_size, mem_addr[1:0]);
    end
  end

endmodule

// ==== hdl/dcache_subsys.sv ====
// Cache subsystem: data cache in front of the main memory model
`timescale 1ns/1ps

module dcache_subsys #(
  parameter int ACK_DELAY = 3,
  parameter int COUNT_W   = 16
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         cpu_req,
  input  logic                         cpu_write,
  input  cache_ctrl_pkg::access_size_t cpu_size,
  input  cache_cfg_pkg::addr_t         cpu_addr,
  input  cache_cfg_pkg::word_t         cpu_wdata,
  output logic                         cpu_wait,
  output cache_cfg_pkg::word_t         cpu_rdata,
  output logic [COUNT_W-1:0]           rd_hits,
  output logic [COUNT_W-1:0]           rd_misses,
  output logic [COUNT_W-1:0]           wr_hits,
  output logic [COUNT_W-1:0]           wr_misses
);

  logic                         mem_req;
  logic                         mem_write;
  cache_cfg_pkg::addr_t         mem_addr;
  cache_cfg_pkg::word_t         mem_wdata;
  cache_ctrl_pkg::access_size_t mem_size;
  logic                         mem_ack;
  cache_cfg_pkg::word_t         mem_rdata;

  dcache #(.COUNT_W(COUNT_W)) i_dcache (
    .clk       (clk),
    .rstn      (rstn),
    .cpu_req   (cpu_req),
    .cpu_write (cpu_write),
    .cpu_size  (cpu_size),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_wait  (cpu_wait),
    .cpu_rdata (cpu_rdata),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_size  (mem_size),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .rd_hits   (rd_hits),
    .rd_misses (rd_misses),
    .wr_hits   (wr_hits),
    .wr_misses (wr_misses)
  );

  bus_mem #(.ACK_DELAY(ACK_DELAY)) i_bus_mem (
    .clk       (clk),
    .rstn      (rstn),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_size  (mem_size),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

// ==== bench/tb_dcache.sv ====
// Testbench for the data cache subsystem
// Table and random accesses checked against a model of memory and cache tags
`timescale 1ns/1ps

module tb_dcache;

  localparam int CLK_PERIOD  = 4;
  localparam int ACK_DELAY   = 3;
  localparam int COUNT_W     = 16;
  localparam int NUM_ENTRIES = 23;
  localparam int NUM_RANDOM  = 200;
  // Worst case is a tag check followed by a full refill
  localparam int ACCESS_MAX  = ACK_DELAY + 10;
  localparam int WATCHDOG_NS = (NUM_ENTRIES + NUM_RANDOM + 10) * ACCESS_MAX * CLK_PERIOD;

  localparam logic [1:0] SZ_B = 2'd0;
  localparam logic [1:0] SZ_H = 2'd1;
  localparam logic [1:0] SZ_W = 2'd2;

  typedef struct packed {
    logic                 wr;
    logic [1:0]           size;
    cache_cfg_pkg::addr_t addr;
    cache_cfg_pkg::word_t wdata;
    logic                 hit;
    cache_cfg_pkg::word_t rdata;
  } entry_t;

  // write, size, address, write data, expected hit, expected read data
  localparam entry_t STIMULUS [NUM_ENTRIES] = '{
    '{1'b1, SZ_W, 12'h120, 32'h1122_3344, 1'b0, 32'h0000_0000},
    '{1'b1, SZ_W, 12'h124, 32'h5566_7788, 1'b0, 32'h0000_0000},
    '{1'b0, SZ_W, 12'h120, 32'h0000_0000, 1'b0, 32'h1122_3344},
    '{1'b0, SZ_W, 12'h124, 32'h0000_0000, 1'b1, 32'h5566_7788},
    '{1'b1, SZ_B, 12'h121, 32'hFFFF_FFAB, 1'b1, 32'h0000_0000},
    '{1'b1, SZ_H, 12'h126, 32'h9999_CDEF, 1'b1, 32'h0000_0000},
    '{1'b1, SZ_W, 12'h128, 32'hDEAD_BEEF, 1'b1, 32'h0000_0000},
    '{1'b0, SZ_W, 12'h120, 32'h0000_0000, 1'b1, 32'h1122_AB44},
    '{1'b0, SZ_H, 12'h126, 32'h0000_0000, 1'b1, 32'h0000_CDEF},
    '{1'b0, SZ_B, 12'h121, 32'h0000_0000, 1'b1, 32'h0000_00AB},
    '{1'b0, SZ_W, 12'h128, 32'h0000_0000, 1'b1, 32'hDEAD_BEEF},
    '{1'b0, SZ_W, 12'h320, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{1'b0, SZ_W, 12'h120, 32'h0000_0000, 1'b0, 32'h1122_AB44},
    '{1'b0, SZ_W, 12'h124, 32'h0000_0000, 1'b1, 32'hCDEF_7788},
    '{1'b0, SZ_W, 12'h128, 32'h0000_0000, 1'b1, 32'hDEAD_BEEF},
    '{1'b1, SZ_W, 12'h450, 32'h0BAD_F00D, 1'b0, 32'h0000_0000},
    '{1'b0, SZ_W, 12'h450, 32'h0000_0000, 1'b0, 32'h0BAD_F00D},
    '{1'b1, SZ_B, 12'h453, 32'h1234_567E, 1'b1, 32'h0000_0000},
    '{1'b0, SZ_B, 12'h453, 32'h0000_0000, 1'b1, 32'h0000_007E},
    '{1'b0, SZ_H, 12'h452, 32'h0000_0000, 1'b1, 32'h0000_7EAD},
    '{1'b1, SZ_W, 12'h554, 32'h1234_5678, 1'b0, 32'h0000_0000},
    '{1'b0, SZ_W, 12'h554, 32'h0000_0000, 1'b0, 32'h1234_5678},
    '{1'b0, SZ_W, 12'h450, 32'h0000_0000, 1'b0, 32'h7EAD_F00D}
  };

  logic                         clk;
  logic                         rstn;
  logic                         cpu_req;
  logic                         cpu_write;
  cache_ctrl_pkg::access_size_t cpu_size;
  cache_cfg_pkg::addr_t         cpu_addr;
  cache_cfg_pkg::word_t         cpu_wdata;
  logic                         cpu_wait;
  cache_cfg_pkg::word_t         cpu_rdata;
  logic [COUNT_W-1:0]           rd_hits;
  logic [COUNT_W-1:0]           rd_misses;
  logic [COUNT_W-1:0]           wr_hits;
  logic [COUNT_W-1:0]           wr_misses;

  // Reference model state
  cache_cfg_pkg::word_t mem_model [2 ** (cache_cfg_pkg::ADDR_W - 2)];
  logic [15:0]          valid_model;
  cache_cfg_pkg::tag_t  tag_model [16];
  int                   n_rd_hit;
  int                   n_rd_miss;
  int                   n_wr_hit;
  int                   n_wr_miss;
  logic [31:0]          lfsr;

  dcache_subsys #(.ACK_DELAY(ACK_DELAY), .COUNT_W(COUNT_W)) i_dcache_subsys (
    .clk       (clk),
    .rstn      (rstn),
    .cpu_req   (cpu_req),
    .cpu_write (cpu_write),
    .cpu_size  (cpu_size),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_wait  (cpu_wait),
    .cpu_rdata (cpu_rdata),
    .rd_hits   (rd_hits),
    .rd_misses (rd_misses),
    .wr_hits   (wr_hits),
    .wr_misses (wr_misses)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the cache did not finish its accesses before the watchdog expired");
    $display("Errors found");
    $fatal(1);
  end

  // ====================================================================
  // Helpers
  // ====================================================================
  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // Store data is right aligned and lands on the addressed lanes
  function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [1:0] size,
                                              input logic [1:0] off, input logic [31:0] wdata);
    logic [31:0] merged;
    merged = old;
    if (size == SZ_B) begin
      merged[off*8 +: 8] = wdata[7:0];
    end else if (size == SZ_H) begin
      merged[off[1]*16 +: 16] = wdata[15:0];
    end else begin
      merged = wdata;
    end
    return merged;
  endfunction

  function automatic logic [31:0] read_lane(input logic [31:0] w, input logic [1:0] size,
                                            input logic [1:0] off);
    if (size == SZ_B) return (w >> (off * 8)) & 32'h0000_00FF;
    if (size == SZ_H) return (w >> (off[1] * 16)) & 32'h0000_FFFF;
    return w;
  endfunction

  // One CPU access followed by model update and checks against the model
  task automatic run_access(input logic wr, input logic [1:0] size,
                            input cache_cfg_pkg::addr_t addr, input cache_cfg_pkg::word_t wdata,
                            output logic hit, output cache_cfg_pkg::word_t rdata);
    int                        cycles;
    logic                      exp_hit;
    logic [COUNT_W-1:0]        hits_before;
    cache_cfg_pkg::index_t     idx;
    cache_cfg_pkg::tag_t       tag;
    cache_cfg_pkg::mem_index_t widx;
    idx         = addr[7:4];
    tag         = addr[11:8];
    widx        = addr[11:2];
    exp_hit     = valid_model[idx] && (tag_model[idx] == tag);
    hits_before = rd_hits + wr_hits;
    cpu_req   = 1'b1;
    cpu_write = wr;
    cpu_size  = cache_ctrl_pkg::access_size_t'(size);
    cpu_addr  = addr;
    cpu_wdata = wdata;
    @(posedge clk);
    #1;
    cpu_req = 1'b0;
    cycles  = 0;
    while (cpu_wait) begin
      cycles++;
      @(posedge clk);
      #1;
    end
    rdata = cpu_rdata;
    // Hit as the DUT counted it
    hit   = ((rd_hits + wr_hits) != hits_before);
    if (wr) begin
      mem_model[widx] = merge_write(mem_model[widx], size, addr[1:0], wdata);
      if (exp_hit) n_wr_hit++;
      else         n_wr_miss++;
    end else begin
      compare(rdata, read_lane(mem_model[widx], size, addr[1:0]), "read data");
      if (exp_hit) begin
        n_rd_hit++;
        compare(32'(cycles), 32'd1, "read hit wait cycles");
      end else begin
        n_rd_miss++;
        valid_model[idx] = 1'b1;
        tag_model[idx]   = tag;
      end
    end
    compare(32'(rd_hits), 32'(n_rd_hit), "read hit count");
    compare(32'(rd_misses), 32'(n_rd_miss), "read miss count");
    compare(32'(wr_hits), 32'(n_wr_hit), "write hit count");
    compare(32'(wr_misses), 32'(n_wr_miss), "write miss count");
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    logic                  hit;
    cache_cfg_pkg::word_t  rdata;
    logic                  wr;
    logic [1:0]            sz;
    logic [1:0]            tsel;
    cache_cfg_pkg::tag_t   tag;
    logic [2:0]            idx;
    logic [1:0]            wsel;
    logic [1:0]            bsel;
    cache_cfg_pkg::word_t  data;
    rstn      = 1'b0;
    cpu_req   = 1'b0;
    cpu_write = 1'b0;
    cpu_size  = cache_ctrl_pkg::SIZE_WORD;
    cpu_addr  = '0;
    cpu_wdata = '0;
    lfsr      = 32'd67198;
    valid_model = '0;
    n_rd_hit  = 0;
    n_rd_miss = 0;
    n_wr_hit  = 0;
    n_wr_miss = 0;
    foreach (mem_model[i]) mem_model[i] = '0;
    foreach (tag_model[i]) tag_model[i] = '0;

    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    compare(32'(cpu_wait), 32'd0, "cpu_wait after reset");
    compare(32'(rd_hits | rd_misses | wr_hits | wr_misses), 32'd0, "counts after reset");

    for (int e = 0; e < NUM_ENTRIES; e++) begin
      run_access(STIMULUS[e].wr, STIMULUS[e].size, STIMULUS[e].addr, STIMULUS[e].wdata,
                 hit, rdata);
      compare(32'(hit), 32'(STIMULUS[e].hit), "hit classification");
      if (!STIMULUS[e].wr) compare(rdata, STIMULUS[e].rdata, "table read data");
    end

    // Three tags over eight lines give both hits and conflicts
    for (int n = 0; n < NUM_RANDOM; n++) begin
      wr   = 1'(lfsr_bits(1));
      sz   = 2'(lfsr_bits(2));
      tsel = 2'(lfsr_bits(2));
      idx  = 3'(lfsr_bits(3));
      wsel = 2'(lfsr_bits(2));
      bsel = 2'(lfsr_bits(2));
      data = lfsr_bits(32);
      if (sz == 2'd3) sz = SZ_W;
      tag = (tsel == 2'd0) ? 4'h1 : ((tsel == 2'd1) ? 4'h3 : 4'h4);
      if (sz == SZ_H) bsel = {bsel[1], 1'b0};
      else if (sz == SZ_W) bsel = 2'd0;
      run_access(wr, sz, {tag, 1'b0, idx, wsel, bsel}, data, hit, rdata);
    end

    $display("No errors");
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/cache_cfg_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/sram_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_perf.sv
hdl/dcache.sv
hdl/bus_mem.sv
hdl/dcache_subsys.sv
bench/tb_dcache.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
SIM_DIR   ?= build
TOP       ?= tb_dcache
VFLAGS    ?= --binary --timing -Wno-fatal
FILELIST  ?= tb.f
LOG       ?= $(SIM_DIR)/sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR)
